/* list.f */
logic/cgmii_gen_pkg.sv
logic/frame_sequencer.sv
logic/prbs_payload.sv
logic/cgmii_block_builder.sv
logic/tx_stats.sv
logic/cgmii_gen_top.sv
tests/clock_gen.sv
tests/tb_cgmii_gen.sv

/* logic/cgmii_block_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module cgmii_block_builder (
	input  wire logic                                  i_clock,
	input  wire logic                                  i_reset,
	input  wire cgmii_gen_pkg::seq_status_t            i_status,
	input  wire logic [cgmii_gen_pkg::PAYLOAD_NBIT-1:0] i_payload,
	output cgmii_gen_pkg::cgmii_word_t                 o_block
);

	cgmii_gen_pkg::cgmii_word_t block_next;
	cgmii_gen_pkg::cgmii_word_t block_q;
	cgmii_gen_pkg::cgmii_word_t idle_word;

	// Reset value and the INIT/TX_C pattern
	always_comb begin
		for (int i = 0; i < cgmii_gen_pkg::LANES; i++) begin
			idle_word.data[8*i +: 8] = cgmii_gen_pkg::CH_IDLE;
		end
		idle_word.ctrl = '1;
	end

	always_comb begin
		block_next = idle_word;
		case (i_status.state)
			cgmii_gen_pkg::ST_INIT, cgmii_gen_pkg::ST_TX_C: begin
				block_next = idle_word;
			end
			cgmii_gen_pkg::ST_TX_D: begin
				if (i_status.first_data) begin
					block_next.data[7:0] = cgmii_gen_pkg::CH_START;
					for (int i = 1; i < cgmii_gen_pkg::LANES - 1; i++) begin
						block_next.data[8*i +: 8] = cgmii_gen_pkg::CH_PREAMBLE;
					end
					block_next.data[8*(cgmii_gen_pkg::LANES-1) +: 8] = cgmii_gen_pkg::CH_SFD;
					block_next.ctrl = cgmii_gen_pkg::LANES'(1);	// Only the start lane
				end else begin
					block_next.data = i_payload;
					block_next.ctrl = '0;
				end
			end
			cgmii_gen_pkg::ST_TX_T: begin
				block_next.data[7:0] = cgmii_gen_pkg::CH_TERM;	// Rest stay idle
			end
			default: begin
				// TX_E and any broken state
				for (int i = 0; i < cgmii_gen_pkg::LANES; i++) begin
					block_next.data[8*i +: 8] = cgmii_gen_pkg::CH_ERROR;
				end
				block_next.ctrl = '1;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			block_q <= idle_word;
		end else if (i_status.step) begin
			block_q <= block_next;
		end
	end

	assign o_block = block_q;

endmodule

`default_nettype wire

/* logic/cgmii_gen_pkg.sv */
`default_nettype none

package cgmii_gen_pkg;

	localparam int LANES        = 8;
	localparam int PAYLOAD_NBIT = 8 * LANES;	// One byte per lane
	localparam int IDLE_NBIT    = 5;
	localparam int DATA_NBIT    = 8;
	localparam int DEBUG_NBIT   = 4;
	localparam int STAT_NBIT    = 16;

	// One-hot sequencer states
	localparam logic [4:0] ST_INIT = 5'b00001;
	localparam logic [4:0] ST_TX_C = 5'b00010;
	localparam logic [4:0] ST_TX_D = 5'b00100;
	localparam logic [4:0] ST_TX_T = 5'b01000;
	localparam logic [4:0] ST_TX_E = 5'b10000;

	localparam logic [DEBUG_NBIT-1:0] DBG_NONE  = 4'b0000;
	localparam logic [DEBUG_NBIT-1:0] DBG_ERROR = 4'b0001;	// Force error state
	localparam logic [DEBUG_NBIT-1:0] DBG_CTRL  = 4'b0010;	// Force control state
	localparam logic [DEBUG_NBIT-1:0] DBG_DATA  = 4'b0100;	// Force data state
	localparam logic [DEBUG_NBIT-1:0] DBG_DCNT1 = 4'b1000;	// Data counter to one
	localparam logic [DEBUG_NBIT-1:0] DBG_TERM  = 4'b1111;	// Force terminate

	// CGMII characters
	localparam logic [7:0] CH_IDLE     = 8'h07;
	localparam logic [7:0] CH_START    = 8'hFB;
	localparam logic [7:0] CH_TERM     = 8'hFD;
	localparam logic [7:0] CH_ERROR    = 8'hFE;
	localparam logic [7:0] CH_PREAMBLE = 8'h55;
	localparam logic [7:0] CH_SFD      = 8'hD5;

	localparam logic [6:0] PRBS_SEED = 7'h7F;

	typedef struct packed {
		logic [IDLE_NBIT-1:0] n_idle;
		logic [DATA_NBIT-1:0] n_data;
	} frame_cfg_t;

	typedef struct packed {
		logic [4:0] state;
		logic       first_data;	// First TX_D cycle after TX_C
		logic       step;		// Enable seen this cycle
	} seq_status_t;

	typedef struct packed {
		logic [PAYLOAD_NBIT-1:0] data;	// Lane 0 in the low byte
		logic [LANES-1:0]        ctrl;	// Bit i flags lane i
	} cgmii_word_t;

	typedef struct packed {
		logic [STAT_NBIT-1:0] frames;
		logic [STAT_NBIT-1:0] errors;
	} stats_t;

endpackage

`default_nettype wire

/* logic/cgmii_gen_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cgmii_gen_top (
	input  wire logic                                i_clock,
	input  wire logic                                i_reset,
	input  wire logic                                i_enable,
	input  wire logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] i_debug,
	input  wire cgmii_gen_pkg::frame_cfg_t           i_cfg,
	output cgmii_gen_pkg::cgmii_word_t              o_block,
	output logic                                     o_start_flag,
	output cgmii_gen_pkg::stats_t                   o_stats
);

	cgmii_gen_pkg::seq_status_t              status;
	logic [cgmii_gen_pkg::PAYLOAD_NBIT-1:0] payload;

	frame_sequencer u_sequencer (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_enable     (i_enable),
		.i_debug      (i_debug),
		.i_cfg        (i_cfg),
		.o_status     (status),
		.o_start_flag (o_start_flag)
	);

	prbs_payload u_prbs (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_status  (status),
		.o_payload (payload)
	);

	cgmii_block_builder u_builder (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_status  (status),
		.i_payload (payload),
		.o_block   (o_block)
	);

	// Watches the registered word leaving the builder
	tx_stats u_stats (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_block  (o_block),
		.o_stats  (o_stats)
	);

endmodule

`default_nettype wire

/* logic/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
	input  wire logic                                i_clock,
	input  wire logic                                i_reset,
	input  wire logic                                i_enable,
	input  wire logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] i_debug,
	input  wire cgmii_gen_pkg::frame_cfg_t           i_cfg,
	output cgmii_gen_pkg::seq_status_t              o_status,
	output logic                                     o_start_flag
);

	logic [4:0]                          state_q;
	logic [4:0]                          state_next;
	logic [cgmii_gen_pkg::IDLE_NBIT-1:0] idle_cnt_q;
	logic [cgmii_gen_pkg::IDLE_NBIT-1:0] idle_cnt_next;
	logic [cgmii_gen_pkg::DATA_NBIT-1:0] data_cnt_q;
	logic [cgmii_gen_pkg::DATA_NBIT-1:0] data_cnt_next;
	logic                                first_data_q;
	logic                                first_data_next;
	logic                                first_load_q;	// Waiting for first enable
	logic                                reload;
	cgmii_gen_pkg::frame_cfg_t           cfg_q;

	always_comb begin
		state_next      = state_q;
		idle_cnt_next   = idle_cnt_q;
		data_cnt_next   = data_cnt_q;
		first_data_next = 1'b0;
		reload          = 1'b0;

		case (i_debug)
			cgmii_gen_pkg::DBG_NONE: begin
				case (state_q)
					cgmii_gen_pkg::ST_INIT: begin
						state_next = cgmii_gen_pkg::ST_TX_C;
					end
					cgmii_gen_pkg::ST_TX_C: begin
						if (idle_cnt_q < cfg_q.n_idle) begin
							idle_cnt_next = idle_cnt_q + 1'b1;
						end else begin
							idle_cnt_next   = '0;
							state_next      = cgmii_gen_pkg::ST_TX_D;
							first_data_next = 1'b1;	// Start of frame
						end
					end
					cgmii_gen_pkg::ST_TX_D: begin
						if (data_cnt_q < cfg_q.n_data) begin
							data_cnt_next = data_cnt_q + 1'b1;
						end else begin
							data_cnt_next = '0;
							state_next    = cgmii_gen_pkg::ST_TX_T;
						end
					end
					cgmii_gen_pkg::ST_TX_T: begin
						reload     = 1'b1;	// New lengths for next frame
						state_next = cgmii_gen_pkg::ST_INIT;
					end
					cgmii_gen_pkg::ST_TX_E: begin
						state_next = cgmii_gen_pkg::ST_TX_C;
					end
					default: begin
						state_next = cgmii_gen_pkg::ST_TX_E;
					end
				endcase
			end
			cgmii_gen_pkg::DBG_ERROR: begin
				state_next    = cgmii_gen_pkg::ST_TX_E;
				idle_cnt_next = '0;
				data_cnt_next = '0;
			end
			cgmii_gen_pkg::DBG_CTRL: begin
				state_next = cgmii_gen_pkg::ST_TX_C;
			end
			cgmii_gen_pkg::DBG_DATA: begin
				state_next = cgmii_gen_pkg::ST_TX_D;	// No start block
			end
			cgmii_gen_pkg::DBG_DCNT1: begin
				data_cnt_next = cgmii_gen_pkg::DATA_NBIT'(1);
			end
			cgmii_gen_pkg::DBG_TERM: begin
				state_next = cgmii_gen_pkg::ST_TX_T;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q      <= cgmii_gen_pkg::ST_INIT;
			idle_cnt_q   <= '0;
			data_cnt_q   <= '0;
			first_data_q <= 1'b0;
			first_load_q <= 1'b1;
		end else if (i_enable) begin
			if (first_load_q) begin
				state_q      <= cgmii_gen_pkg::ST_INIT;
				first_data_q <= 1'b0;
				first_load_q <= 1'b0;
			end else begin
				state_q      <= state_next;
				idle_cnt_q   <= idle_cnt_next;
				data_cnt_q   <= data_cnt_next;
				first_data_q <= first_data_next;
			end
		end
	end

	// Frame lengths latched at start and after each terminate
	always_ff @(posedge i_clock) begin
		if (i_enable && (first_load_q || reload)) begin
			cfg_q <= i_cfg;
		end
	end

	assign o_status.state      = state_q;
	assign o_status.first_data = first_data_q;
	assign o_status.step       = i_enable;
	assign o_start_flag        = first_data_q;	// Same register as the TX_C to TX_D move

endmodule

`default_nettype wire

/* logic/prbs_payload.sv */
`timescale 1ns/1ps
`default_nettype none

module prbs_payload (
	input  wire logic                                  i_clock,
	input  wire logic                                  i_reset,
	input  wire cgmii_gen_pkg::seq_status_t            i_status,
	output logic [cgmii_gen_pkg::PAYLOAD_NBIT-1:0]     o_payload
);

	logic [6:0]                              prbs_q;
	logic [6:0]                              prbs_next;
	logic [6:0]                              lfsr;
	logic                                    feedback;
	logic [cgmii_gen_pkg::PAYLOAD_NBIT-1:0] bits;
	logic                                    advance;

	// x^7 + x^6 + 1, unrolled over one full word
	always_comb begin
		lfsr = prbs_q;
		bits = '0;
		feedback = 1'b0;
		for (int i = 0; i < cgmii_gen_pkg::PAYLOAD_NBIT; i++) begin
			feedback = lfsr[6] ^ lfsr[5];
			bits[i]  = feedback;	// First bit lands in lane 0 bit 0
			lfsr     = {lfsr[5:0], feedback};
		end
		prbs_next = lfsr;
	end

	// Only real payload blocks consume sequence bits
	assign advance = i_status.step
		&& (i_status.state == cgmii_gen_pkg::ST_TX_D)
		&& !i_status.first_data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prbs_q <= cgmii_gen_pkg::PRBS_SEED;
		end else if (advance) begin
			prbs_q <= prbs_next;
		end
	end

	assign o_payload = bits;

endmodule

`default_nettype wire

/* logic/tx_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_stats (
	input  wire logic                       i_clock,
	input  wire logic                       i_reset,
	input  wire logic                       i_enable,
	input  wire cgmii_gen_pkg::cgmii_word_t i_block,
	output cgmii_gen_pkg::stats_t           o_stats
);

	logic                  updated_q;	// Block register loaded last cycle
	logic                  is_term;
	logic                  is_error;
	cgmii_gen_pkg::stats_t stats_q;

	assign is_term  = i_block.ctrl[0] && (i_block.data[7:0] == cgmii_gen_pkg::CH_TERM);
	assign is_error = i_block.ctrl[0] && (i_block.data[7:0] == cgmii_gen_pkg::CH_ERROR);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			updated_q <= 1'b0;
		end else begin
			updated_q <= i_enable;
		end
	end

	// Counters wrap on overflow
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			stats_q <= '0;
		end else if (updated_q) begin
			if (is_term) begin
				stats_q.frames <= stats_q.frames + 1'b1;
			end
			if (is_error) begin
				stats_q.errors <= stats_q.errors + 1'b1;
			end
		end
	end

	assign o_stats = stats_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the CGMII generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	-f list.f --top-module tb_cgmii_gen \
	-Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$("./$BUILD_DIR/sim")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Done: no errors$"; then
	exit 0
fi

echo "Simulation did not report a clean run"
exit 1

/* tests/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic o_clock
);

	// 10 ns period, starts low
	initial begin
		o_clock = 1'b0;
		forever begin
			#5 o_clock = ~o_clock;	// Half period
		end
	end

endmodule

`default_nettype wire

/* tests/tb_cgmii_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cgmii_gen;

	logic                                 clock;
	logic                                 reset;
	logic                                 enable;
	logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] debug;
	cgmii_gen_pkg::frame_cfg_t            cfg;
	cgmii_gen_pkg::cgmii_word_t           block;
	logic                                 start_flag;
	cgmii_gen_pkg::stats_t                stats;

	logic [4:0]                          m_state;	// Model copy of the sequencer
	logic [cgmii_gen_pkg::IDLE_NBIT-1:0] m_idle_cnt;
	logic [cgmii_gen_pkg::DATA_NBIT-1:0] m_data_cnt;
	logic                                m_first_data;
	logic                                m_first_load;
	cgmii_gen_pkg::frame_cfg_t           m_cfg;
	logic [6:0]                          m_prbs;
	int                                  m_frames;
	int                                  m_errors;

	cgmii_gen_pkg::cgmii_word_t exp_block_next;	// Due after the coming edge
	cgmii_gen_pkg::cgmii_word_t exp_block_cur;
	logic                       exp_flag_next;
	logic                       exp_flag_cur;
	cgmii_gen_pkg::frame_cfg_t  traffic_cfg;
	logic                       check_en;
	int                         error_count;
	int                         check_count;

	clock_gen u_clock (
		.o_clock (clock)
	);

	cgmii_gen_top dut (
		.i_clock      (clock),
		.i_reset      (reset),
		.i_enable     (enable),
		.i_debug      (debug),
		.i_cfg        (cfg),
		.o_block      (block),
		.o_start_flag (start_flag),
		.o_stats      (stats)
	);

	function automatic cgmii_gen_pkg::cgmii_word_t control_word(
		input logic [7:0] lane0,
		input logic [7:0] rest
	);
		cgmii_gen_pkg::cgmii_word_t word;
		word.data = {{7{rest}}, lane0};
		word.ctrl = 8'hFF;
		return word;
	endfunction

	// PRBS7, x^7 + x^6 + 1, first bit into lane 0 bit 0
	function automatic logic [63:0] prbs_bits(input logic [6:0] start, output logic [6:0] finish);
		logic [6:0]  r;
		logic        b;
		logic [63:0] word;
		r = start;
		word = '0;
		for (int i = 0; i < 64; i++) begin
			b       = r[6] ^ r[5];
			word[i] = b;
			r       = {r[5:0], b};
		end
		finish = r;
		return word;
	endfunction

	function automatic void model_reset();
		m_state        = cgmii_gen_pkg::ST_INIT;
		m_idle_cnt     = '0;
		m_data_cnt     = '0;
		m_first_data   = 1'b0;
		m_first_load   = 1'b1;
		m_cfg          = '0;
		m_prbs         = 7'h7F;
		m_frames       = 0;
		m_errors       = 0;
		exp_block_next = control_word(cgmii_gen_pkg::CH_IDLE, cgmii_gen_pkg::CH_IDLE);
		exp_flag_next  = 1'b0;
	endfunction

	// One enabled edge: word built from the old state, then the state moves
	function automatic cgmii_gen_pkg::cgmii_word_t model_step(
		input  logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] dbg,
		input  cgmii_gen_pkg::frame_cfg_t            cfg_in,
		output logic                                 flag
	);
		cgmii_gen_pkg::cgmii_word_t word;
		logic [6:0]                 prbs_after;
		logic                       new_first;

		new_first = 1'b0;
		case (m_state)
			cgmii_gen_pkg::ST_INIT, cgmii_gen_pkg::ST_TX_C: begin
				word = control_word(cgmii_gen_pkg::CH_IDLE, cgmii_gen_pkg::CH_IDLE);
			end
			cgmii_gen_pkg::ST_TX_D: begin
				if (m_first_data) begin
					word.data = {cgmii_gen_pkg::CH_SFD, {6{cgmii_gen_pkg::CH_PREAMBLE}},
						cgmii_gen_pkg::CH_START};
					word.ctrl = 8'h01;
				end else begin
					word.data = prbs_bits(m_prbs, prbs_after);
					word.ctrl = 8'h00;
					m_prbs    = prbs_after;	// Payload blocks consume the sequence
				end
			end
			cgmii_gen_pkg::ST_TX_T: begin
				word = control_word(cgmii_gen_pkg::CH_TERM, cgmii_gen_pkg::CH_IDLE);
				m_frames++;
			end
			default: begin
				word = control_word(cgmii_gen_pkg::CH_ERROR, cgmii_gen_pkg::CH_ERROR);
				m_errors++;
			end
		endcase

		if (m_first_load) begin
			m_first_load = 1'b0;	// First enabled edge only latches the lengths
			m_cfg        = cfg_in;
			m_state      = cgmii_gen_pkg::ST_INIT;
		end else begin
			case (dbg)
				cgmii_gen_pkg::DBG_NONE: begin
					case (m_state)
						cgmii_gen_pkg::ST_INIT: begin
							m_state = cgmii_gen_pkg::ST_TX_C;
						end
						cgmii_gen_pkg::ST_TX_C: begin
							if (m_idle_cnt < m_cfg.n_idle) begin
								m_idle_cnt = m_idle_cnt + 1'b1;
							end else begin
								m_idle_cnt = '0;
								m_state    = cgmii_gen_pkg::ST_TX_D;
								new_first  = 1'b1;
							end
						end
						cgmii_gen_pkg::ST_TX_D: begin
							if (m_data_cnt < m_cfg.n_data) begin
								m_data_cnt = m_data_cnt + 1'b1;
							end else begin
								m_data_cnt = '0;
								m_state    = cgmii_gen_pkg::ST_TX_T;
							end
						end
						cgmii_gen_pkg::ST_TX_T: begin
							m_cfg   = cfg_in;	// Lengths for the next frame
							m_state = cgmii_gen_pkg::ST_INIT;
						end
						cgmii_gen_pkg::ST_TX_E: begin
							m_state = cgmii_gen_pkg::ST_TX_C;
						end
						default: begin
							m_state = cgmii_gen_pkg::ST_TX_E;
						end
					endcase
				end
				cgmii_gen_pkg::DBG_ERROR: begin
					m_state    = cgmii_gen_pkg::ST_TX_E;
					m_idle_cnt = '0;
					m_data_cnt = '0;
				end
				cgmii_gen_pkg::DBG_CTRL: m_state = cgmii_gen_pkg::ST_TX_C;
				cgmii_gen_pkg::DBG_DATA: m_state = cgmii_gen_pkg::ST_TX_D;
				cgmii_gen_pkg::DBG_DCNT1: m_data_cnt = 8'd1;
				cgmii_gen_pkg::DBG_TERM: m_state = cgmii_gen_pkg::ST_TX_T;
				default: begin
				end
			endcase
		end
		m_first_data = new_first;
		flag         = new_first;
		return word;
	endfunction

	function automatic cgmii_gen_pkg::stats_t model_stats();
		cgmii_gen_pkg::stats_t s;
		s.frames = m_frames[cgmii_gen_pkg::STAT_NBIT-1:0];	// Counters wrap
		s.errors = m_errors[cgmii_gen_pkg::STAT_NBIT-1:0];
		return s;
	endfunction

	function automatic cgmii_gen_pkg::frame_cfg_t random_cfg();
		cgmii_gen_pkg::frame_cfg_t c;
		int unsigned               r_idle;
		int unsigned               r_data;
		r_idle   = $urandom_range(6, 0);
		r_data   = $urandom_range(12, 0);
		c.n_idle = r_idle[cgmii_gen_pkg::IDLE_NBIT-1:0];
		c.n_data = r_data[cgmii_gen_pkg::DATA_NBIT-1:0];
		return c;
	endfunction

	function automatic logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] random_debug();
		case ($urandom_range(5, 0))
			0: return cgmii_gen_pkg::DBG_ERROR;
			1: return cgmii_gen_pkg::DBG_CTRL;
			2: return cgmii_gen_pkg::DBG_DATA;
			3: return cgmii_gen_pkg::DBG_DCNT1;
			4: return cgmii_gen_pkg::DBG_TERM;
			default: return 4'b0110;	// Unlisted code holds the state
		endcase
	endfunction

	task automatic check_block(input cgmii_gen_pkg::cgmii_word_t got,
		input cgmii_gen_pkg::cgmii_word_t want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("ERR %0t: o_block data=%h ctrl=%h, expected data=%h ctrl=%h",
				$time, got.data, got.ctrl, want.data, want.ctrl);
		end
	endtask

	task automatic check_flag(input logic got, input logic want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("ERR %0t: o_start_flag=%b, expected %b", $time, got, want);
		end
	endtask

	task automatic check_stats(input cgmii_gen_pkg::stats_t got, input cgmii_gen_pkg::stats_t want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("ERR %0t: o_stats frames=%0d errors=%0d, expected frames=%0d errors=%0d",
				$time, got.frames, got.errors, want.frames, want.errors);
		end
	endtask

	// Inputs change 1 ns after the edge, the model runs for the next edge
	task automatic drive_cycle(input logic en, input logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] dbg,
		input cgmii_gen_pkg::frame_cfg_t c);
		logic flag;
		@(posedge clock);
		#1;
		enable = en;
		debug  = dbg;
		cfg    = c;
		if (en) begin
			exp_block_next = model_step(dbg, c, flag);
			exp_flag_next  = flag;
		end
	endtask

	// Enabled cycles with no debug code
	task automatic run_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			drive_cycle(1'b1, cgmii_gen_pkg::DBG_NONE, traffic_cfg);
		end
	endtask

	task automatic run_traffic(input int frames, input int stall_pct, input bit churn,
		input int dbg_pct);
		int                                   target;
		int                                   cycles;
		logic                                 en;
		logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] dbg;
		target = m_frames + frames;
		cycles = 0;
		while (m_frames < target && cycles < 4000) begin
			en  = ($urandom_range(99, 0) >= stall_pct);
			dbg = cgmii_gen_pkg::DBG_NONE;
			if ($urandom_range(99, 0) < dbg_pct) begin
				dbg = random_debug();
			end
			if (churn && $urandom_range(3, 0) == 0) begin
				traffic_cfg = random_cfg();	// Mid-frame change
			end
			drive_cycle(en, dbg, traffic_cfg);
			cycles++;
		end
		if (m_frames < target) begin
			error_count++;
			$display("Timeout: %0d frames did not finish within 4000 cycles", frames);
		end
	endtask

	task automatic wait_state(input logic [4:0] st, input int limit);
		int cycles;
		cycles = 0;
		while (m_state != st && cycles < limit) begin
			drive_cycle(1'b1, cgmii_gen_pkg::DBG_NONE, traffic_cfg);
			cycles++;
		end
		if (m_state != st) begin
			error_count++;
			$display("Timeout: sequencer never reached state %b in %0d cycles", st, limit);
		end
	endtask

	// Code applied in the given state, then two cycles so its block shows
	task automatic force_code(input logic [cgmii_gen_pkg::DEBUG_NBIT-1:0] code,
		input logic [4:0] at_state);
		wait_state(at_state, 200);
		drive_cycle(1'b1, code, traffic_cfg);
		drive_cycle(1'b1, cgmii_gen_pkg::DBG_NONE, traffic_cfg);
		drive_cycle(1'b1, cgmii_gen_pkg::DBG_NONE, traffic_cfg);
	endtask

	task automatic finish_test(input int num, input string name, input int errors_before);
		drive_cycle(1'b0, cgmii_gen_pkg::DBG_NONE, traffic_cfg);
		drive_cycle(1'b0, cgmii_gen_pkg::DBG_NONE, traffic_cfg);	// Stats lag one cycle
		check_stats(stats, model_stats());
		$display("Test %0d %s: %s", num, name,
			(error_count == errors_before) ? "passed" : "failed");
	endtask

	always @(posedge clock) begin
		exp_block_cur <= exp_block_next;
		exp_flag_cur  <= exp_flag_next;
	end

	// Mid-cycle compare against the model
	always @(negedge clock) begin
		if (check_en) begin
			check_block(block, exp_block_cur);
			check_flag(start_flag, exp_flag_cur);
		end
	end

	initial begin
		int errs;
		void'($urandom(32'h551c_d911));
		reset       = 1'b1;
		enable      = 1'b0;
		debug       = '0;
		cfg         = '0;
		traffic_cfg = '0;
		check_en    = 1'b0;
		error_count = 0;
		check_count = 0;
		model_reset();
		repeat (16) @(posedge clock);
		#1;
		reset    = 1'b0;
		check_en = 1'b1;

		errs = error_count;
		check_block(block, control_word(cgmii_gen_pkg::CH_IDLE, cgmii_gen_pkg::CH_IDLE));
		check_flag(start_flag, 1'b0);
		check_stats(stats, '0);
		$display("Test 1 reset values: %s", (error_count == errs) ? "passed" : "failed");

		errs = error_count;
		for (int f = 0; f < 8; f++) begin
			traffic_cfg = random_cfg();
			run_traffic(1, 0, 1'b0, 0);
		end
		finish_test(2, "normal frames", errs);

		errs = error_count;
		wait_state(cgmii_gen_pkg::ST_TX_D, 200);
		run_traffic(6, 0, 1'b1, 0);
		finish_test(3, "config change mid-frame", errs);

		errs = error_count;
		run_traffic(6, 30, 1'b0, 0);
		finish_test(4, "enable stalls", errs);

		errs = error_count;
		traffic_cfg.n_idle = 5'd3;
		traffic_cfg.n_data = 8'd6;
		run_traffic(1, 0, 1'b0, 0);
		wait_state(cgmii_gen_pkg::ST_TX_D, 200);
		run_cycles(3);	// Data counter away from zero
		force_code(cgmii_gen_pkg::DBG_ERROR, cgmii_gen_pkg::ST_TX_D);
		check_block(block, control_word(cgmii_gen_pkg::CH_ERROR, cgmii_gen_pkg::CH_ERROR));
		force_code(cgmii_gen_pkg::DBG_DATA, cgmii_gen_pkg::ST_TX_C);
		run_traffic(1, 0, 1'b0, 0);
		force_code(cgmii_gen_pkg::DBG_DCNT1, cgmii_gen_pkg::ST_TX_C);	// Next data run one shorter
		force_code(cgmii_gen_pkg::DBG_CTRL, cgmii_gen_pkg::ST_TX_D);
		force_code(4'b0011, cgmii_gen_pkg::ST_TX_C);
		force_code(cgmii_gen_pkg::DBG_TERM, cgmii_gen_pkg::ST_TX_D);
		check_block(block, control_word(cgmii_gen_pkg::CH_TERM, cgmii_gen_pkg::CH_IDLE));
		run_traffic(2, 0, 1'b0, 0);
		finish_test(5, "debug codes", errs);

		errs = error_count;
		traffic_cfg = random_cfg();
		run_traffic(25, 20, 1'b1, 5);
		finish_test(6, "random run and statistics", errs);

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
